/* hw/btbPkg.sv */
// Shared definitions for the branch front end
// BTB geometry, reset PC, branch opcode and the structs passed between blocks
`default_nettype none

package btbPkg;

    // 4 byte instructions, the two low PC bits never take part in lookup
    // Tag plus index cover PC bits 31:2
    localparam int TAG_SIZE   = 20;
    localparam int INDEX_SIZE = 10;

    // First fetch address out of reset
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // RV32 conditional branch major opcode
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

    // One stored BTB line
    typedef struct packed {
        logic                valid;
        logic [TAG_SIZE-1:0] tag;
        logic [2:0]          funct3;
        logic [31:0]         branchImm;
    } btbEntry;

    // Fetch-time lookup result
    typedef struct packed {
        logic        hit;
        logic [31:0] branchImm;
        logic [2:0]  funct3;
    } btbPrediction;

    // Install request issued from decode
    typedef struct packed {
        logic        write;
        logic [31:0] pc;
        logic [31:0] branchImm;
        logic [2:0]  funct3;
    } btbUpdate;

    // Fetched word with its PC and the prediction made for it
    typedef struct packed {
        logic [31:0]  pc;
        logic [31:0]  instr;
        btbPrediction prediction;
    } fetchRecord;

    // Fetch correction from decode
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirectReq;

endpackage : btbPkg

`default_nettype wire

/* hw/fetchPcGen.sv */
// Fetch address generator
// Holds the fetch PC and picks redirect, predicted target or PC+4 each cycle
`timescale 1ns/1ps
`default_nettype none

module fetchPcGen (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              instrF,
    input  btbPkg::btbPrediction     prediction,
    input  btbPkg::redirectReq       redirect,
    output logic [31:0]              pcF,
    output btbPkg::fetchRecord       fetchOut
);

    import btbPkg::*;

    logic [31:0] nextPc;
    logic [31:0] seqPc;
    logic [31:0] predPc;

    // Candidate addresses
    assign seqPc  = pcF + 32'd4;
    assign predPc = pcF + prediction.branchImm;

    // Fixed priority: decode correction beats BTB, BTB beats sequential
    always_comb begin
        if (redirect.valid) begin
            nextPc = redirect.target;
        end else if (prediction.hit) begin
            // Predicted taken on any hit
            nextPc = predPc;
        end else begin
            nextPc = seqPc;
        end
    end

    // Fetch PC advances every cycle, no stall path
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pcF <= RESET_PC;
        end else begin
            pcF <= nextPc;
        end
    end

    // Bundle the fetched word for decode
    // Prediction travels along so decode knows whether fetch already turned
    always_comb begin
        fetchOut.pc         = pcF;
        fetchOut.instr      = instrF;
        fetchOut.prediction = prediction;
    end

endmodule : fetchPcGen

`default_nettype wire

/* hw/branchTargetBuffer.sv */
// Direct-mapped branch target buffer
// Combinational lookup from the fetch PC, one write per cycle from decode
`timescale 1ns/1ps
`default_nettype none

module branchTargetBuffer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              pcF,
    input  btbPkg::btbUpdate         update,
    output btbPkg::btbPrediction     prediction
);

    import btbPkg::*;

    // 2**INDEX_SIZE lines
    btbEntry entries [2**INDEX_SIZE];

    // Read side address split
    logic [INDEX_SIZE-1:0] rdIndex;
    logic [TAG_SIZE-1:0]   rdTag;
    btbEntry               rdEntry;

    // Write side address split
    logic [INDEX_SIZE-1:0] wrIndex;
    logic [TAG_SIZE-1:0]   wrTag;

    assign rdIndex = pcF[INDEX_SIZE+1:2];
    assign rdTag   = pcF[TAG_SIZE+INDEX_SIZE+1:INDEX_SIZE+2];

    assign wrIndex = update.pc[INDEX_SIZE+1:2];
    assign wrTag   = update.pc[TAG_SIZE+INDEX_SIZE+1:INDEX_SIZE+2];

    // Lookup in the fetch cycle
    assign rdEntry = entries[rdIndex];

    // Valid bit keeps an empty line from matching a zero tag
    always_comb begin
        prediction.hit       = rdEntry.valid && (rdEntry.tag == rdTag);
        prediction.branchImm = rdEntry.branchImm;
        prediction.funct3    = rdEntry.funct3;
    end

    // Install from decode
    // Lands at the next edge, a conflicting branch simply replaces the line
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            entries <= '{default: '0};
        end else begin
            if (update.write) begin
                entries[wrIndex].valid     <= 1'b1;
                entries[wrIndex].tag       <= wrTag;
                entries[wrIndex].funct3    <= update.funct3;
                entries[wrIndex].branchImm <= update.branchImm;
            end
        end
    end

endmodule : branchTargetBuffer

`default_nettype wire

/* hw/branchDecoder.sv */
// Decode-stage branch detector
// Finds B-type branches that fetch missed, installs them and redirects fetch
`timescale 1ns/1ps
`default_nettype none

module branchDecoder (
    input  logic                     clk,
    input  logic                     reset,
    input  btbPkg::fetchRecord       fetchIn,
    output btbPkg::btbUpdate         update,
    output btbPkg::redirectReq       redirect,
    output logic [2:0]               predFunct3D
);

    import btbPkg::*;

    // Fetch/decode pipeline register
    fetchRecord fetchD;

    // Decoded fields of the held word
    logic [6:0]  opcodeD;
    logic [2:0]  funct3D;
    logic [31:0] immBD;
    logic        isBranchD;
    logic        missD;

    // Squash on redirect
    // The word fetched alongside the redirect is on the wrong path
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            fetchD <= '0;
        end else if (redirect.valid) begin
            fetchD <= '0;
        end else begin
            fetchD <= fetchIn;
        end
    end

    // Field extraction
    assign opcodeD = fetchD.instr[6:0];
    assign funct3D = fetchD.instr[14:12];

    // B immediate: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    // Bit 0 is always zero, sign taken from bit 31
    assign immBD = {
        {19{fetchD.instr[31]}},
        fetchD.instr[31],
        fetchD.instr[7],
        fetchD.instr[30:25],
        fetchD.instr[11:8],
        1'b0
    };

    // An all-zero squashed record never decodes as a branch
    assign isBranchD = (opcodeD == OPCODE_BRANCH);

    // Branch that fetch stepped past
    // A hit already steered fetch to the target, nothing to fix then
    assign missD = isBranchD && !fetchD.prediction.hit;

    // BTB install, same cycle as the redirect
    always_comb begin
        update.write     = missD;
        update.pc        = fetchD.pc;
        update.branchImm = immBD;
        update.funct3    = funct3D;
    end

    // Static predict-taken on first sight
    always_comb begin
        redirect.valid  = missD;
        redirect.target = fetchD.pc + immBD;
    end

    // Branch kind for issue, meaningful only when the held prediction hit
    assign predFunct3D = fetchD.prediction.funct3;

endmodule : branchDecoder

`default_nettype wire

/* hw/branchFrontEnd.sv */
// Branch front end top level
// Fetch PC generator, BTB and decode branch detector wired together
`timescale 1ns/1ps
`default_nettype none

module branchFrontEnd (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              instrF,
    output logic [31:0]              pcF,
    output logic                     btbHit,
    output btbPkg::redirectReq       redirect,
    output logic [2:0]               predFunct3D
);

    import btbPkg::*;

    // Lookup result, fetch to decode bundle and install request
    btbPrediction prediction;
    fetchRecord   fetchRec;
    btbUpdate     update;

    // Hit is exported for observation
    assign btbHit = prediction.hit;

    fetchPcGen u_fetch (
        .clk        (clk),
        .reset      (reset),
        .instrF     (instrF),
        .prediction (prediction),
        .redirect   (redirect),
        .pcF        (pcF),
        .fetchOut   (fetchRec)
    );

    // Looked up with the same pcF that fetch is using this cycle
    branchTargetBuffer u_btb (
        .clk        (clk),
        .reset      (reset),
        .pcF        (pcF),
        .update     (update),
        .prediction (prediction)
    );

    branchDecoder u_decode (
        .clk         (clk),
        .reset       (reset),
        .fetchIn     (fetchRec),
        .update      (update),
        .redirect    (redirect),
        .predFunct3D (predFunct3D)
    );

endmodule : branchFrontEnd

`default_nettype wire

/* verif/branchFrontEnd_properties.sv */
// Concurrent checks on the front end redirect path
// Reset quiet period, single-cycle redirect and fetch follow-through
`timescale 1ns/1ps
`default_nettype none

module branchFrontEnd_properties (
    input logic        clk,
    input logic        reset,
    input logic        redirectValid,
    input logic [31:0] redirectTarget,
    input logic [31:0] pcF
);

    int assertFails = 0;

    // Quiet during reset and in the first cycle out of it
    noRedirectAroundReset: assert property (@(posedge clk)
        (!reset || $rose(reset)) |-> !redirectValid)
        else begin
            $error("redirect raised during or right after reset");
            assertFails++;
        end

    // Squash keeps the next decode slot empty
    noBackToBackRedirect: assert property (@(posedge clk) disable iff (!reset)
        redirectValid |=> !redirectValid)
        else begin
            $error("redirect held for two cycles");
            assertFails++;
        end

    redirectReachesFetch: assert property (@(posedge clk) disable iff (!reset)
        redirectValid |=> (pcF == $past(redirectTarget)))
        else begin
            $error("pcF did not load the redirect target");
            assertFails++;
        end

endmodule : branchFrontEnd_properties

bind branchFrontEnd branchFrontEnd_properties u_props (
    .clk            (clk),
    .reset          (reset),
    .redirectValid  (redirect.valid),
    .redirectTarget (redirect.target),
    .pcF            (pcF)
);

`default_nettype wire

/* verif/btbChecker.sv */
// Front end reference model and output checker
// Tracks its own BTB, decode register and fetch PC and compares each cycle
`timescale 1ns/1ps
`default_nettype none

module btbChecker (
    input  logic               clk,
    input  logic               reset,
    input  logic [31:0]        pcF,
    input  logic               btbHit,
    input  btbPkg::redirectReq redirect,
    input  logic [2:0]         predFunct3D,
    input  logic               isBranchF,
    input  logic [31:0]        immF,
    input  logic [2:0]         funct3F,
    input  logic [8*16-1:0]    testName,
    output int                 errorCount,
    output int                 hitCount,
    output int                 redirectCount
);

    import btbPkg::*;

    localparam int ENTRIES = 2**INDEX_SIZE;

    // Model BTB
    logic                mValid [ENTRIES];
    logic [TAG_SIZE-1:0] mTag   [ENTRIES];
    logic [31:0]         mImm   [ENTRIES];
    logic [2:0]          mF3    [ENTRIES];

    // Model fetch PC and decode register
    logic [31:0] expPc;
    logic        dBranch;
    logic [31:0] dPc;
    logic [31:0] dImm;
    logic [2:0]  dF3;
    logic        dHit;
    logic [2:0]  dPredF3;

    function automatic logic [INDEX_SIZE-1:0] indexOf(input logic [31:0] pc);
        return pc[INDEX_SIZE+1:2];
    endfunction

    function automatic logic [TAG_SIZE-1:0] tagOf(input logic [31:0] pc);
        return pc[31:INDEX_SIZE+2];
    endfunction

    function automatic logic lookupHit(input logic [31:0] pc);
        return mValid[indexOf(pc)] && (mTag[indexOf(pc)] == tagOf(pc));
    endfunction

    // Model state advances on the same edges as the DUT
    always @(posedge clk or negedge reset) begin
        logic                  hitNow;
        logic                  redirNow;
        logic [31:0]           nextPc;
        logic [2:0]            predF3Now;
        logic [INDEX_SIZE-1:0] idx;
        if (!reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                mValid[i] = 1'b0;
                mTag[i]   = '0;
                mImm[i]   = '0;
                mF3[i]    = '0;
            end
            expPc   = RESET_PC;
            dBranch = 1'b0;
            dPc     = '0;
            dImm    = '0;
            dF3     = '0;
            dHit    = 1'b0;
            dPredF3 = '0;
        end else begin
            idx       = indexOf(expPc);
            hitNow    = lookupHit(expPc);
            predF3Now = mF3[idx];
            redirNow  = dBranch && !dHit;
            // Redirect first, then predicted taken, then sequential
            if (redirNow) begin
                nextPc = dPc + dImm;
            end else if (hitNow) begin
                nextPc = expPc + mImm[idx];
            end else begin
                nextPc = expPc + 32'd4;
            end
            // Missed branch installs its line, replacing any other tag
            if (redirNow) begin
                mValid[indexOf(dPc)] = 1'b1;
                mTag[indexOf(dPc)]   = tagOf(dPc);
                mImm[indexOf(dPc)]   = dImm;
                mF3[indexOf(dPc)]    = dF3;
                // Wrong-path word is dropped
                dBranch = 1'b0;
                dPc     = '0;
                dImm    = '0;
                dF3     = '0;
                dHit    = 1'b0;
                dPredF3 = '0;
            end else begin
                dBranch = isBranchF;
                dPc     = expPc;
                dImm    = immF;
                dF3     = funct3F;
                dHit    = hitNow;
                dPredF3 = predF3Now;
            end
            expPc = nextPc;
        end
    end

    initial begin
        errorCount    = 0;
        hitCount      = 0;
        redirectCount = 0;
    end

    // Compare mid-cycle, away from the edges
    always @(negedge clk) begin
        if (reset) begin
            // Tally what the DUT actually did
            if (btbHit === 1'b1) begin
                hitCount++;
            end
            if (redirect.valid === 1'b1) begin
                redirectCount++;
            end
            if (pcF !== expPc) begin
                $display("ERROR %0s: pcF expected %h actual %h", testName, expPc, pcF);
                errorCount++;
            end
            if (btbHit !== lookupHit(expPc)) begin
                $display("ERROR %0s: btbHit expected %0b actual %0b at pc %h",
                         testName, lookupHit(expPc), btbHit, expPc);
                errorCount++;
            end
            if (redirect.valid !== (dBranch && !dHit)) begin
                $display("ERROR %0s: redirect expected %0b actual %0b",
                         testName, dBranch && !dHit, redirect.valid);
                errorCount++;
            end else if (redirect.valid && (redirect.target !== dPc + dImm)) begin
                $display("ERROR %0s: redirect target expected %h actual %h",
                         testName, dPc + dImm, redirect.target);
                errorCount++;
            end
            // Branch kind only means something after a hit
            if (dHit && (predFunct3D !== dPredF3)) begin
                $display("ERROR %0s: predFunct3D expected %0d actual %0d",
                         testName, dPredF3, predFunct3D);
                errorCount++;
            end
        end
    end

endmodule : btbChecker

`default_nettype wire

/* verif/tb_branchFrontEnd.sv */
// Testbench for the branch front end
// Feeds a small looping program by fetch PC and runs two reset epochs
`timescale 1ns/1ps
`default_nettype none

module tb_branchFrontEnd;

    import btbPkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 10;
    localparam int RUN_FIRST    = 90;
    localparam int RUN_SECOND   = 50;
    localparam int PROG_LEN     = 11;
    // Four times the scheduled cycle count
    localparam int WATCHDOG_CYCLES = (2 * RESET_CYCLES + RUN_FIRST + RUN_SECOND) * 4;
    localparam logic [31:0] NOP = 32'h0000_0013;

    // One program word with what the checker needs to know about it
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] instr;
        logic        isBranch;
        logic [31:0] imm;
        logic [2:0]  funct3;
    } progEntry;

    progEntry           progTable [PROG_LEN];
    logic [8*16-1:0]    progName  [PROG_LEN];

    logic        clk;
    logic        reset;
    logic [31:0] instrF;
    logic [31:0] pcF;
    logic        btbHit;
    redirectReq  redirect;
    logic [2:0]  predFunct3D;

    // Side information for the word at pcF
    logic            isBranchF;
    logic [31:0]     immF;
    logic [2:0]      funct3F;
    logic [8*16-1:0] nameF;

    // Checker tallies
    int checkErrors;
    int hitCount;
    int redirectCount;

    int seed = 43;
    int fillerImm;
    int hitsFirst;
    int redirectsFirst;
    int coverageErrors;
    int totalErrors;

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    branchFrontEnd u_dut (
        .clk         (clk),
        .reset       (reset),
        .instrF      (instrF),
        .pcF         (pcF),
        .btbHit      (btbHit),
        .redirect    (redirect),
        .predFunct3D (predFunct3D)
    );

    btbChecker u_check (
        .clk           (clk),
        .reset         (reset),
        .pcF           (pcF),
        .btbHit        (btbHit),
        .redirect      (redirect),
        .predFunct3D   (predFunct3D),
        .isBranchF     (isBranchF),
        .immF          (immF),
        .funct3F       (funct3F),
        .testName      (nameF),
        .errorCount    (checkErrors),
        .hitCount      (hitCount),
        .redirectCount (redirectCount)
    );

    // Instruction memory stand-in, same cycle as pcF
    // Unlisted addresses read as NOP
    always_comb begin
        instrF    = NOP;
        isBranchF = 1'b0;
        immF      = '0;
        funct3F   = '0;
        nameF     = "unmapped";
        for (int i = 0; i < PROG_LEN; i++) begin
            if (progTable[i].addr == pcF) begin
                instrF    = progTable[i].instr;
                isBranchF = progTable[i].isBranch;
                immF      = progTable[i].imm;
                funct3F   = progTable[i].funct3;
                nameF     = progName[i];
            end
        end
    end

    // B-type layout: imm[12|10:5] rs2 rs1 funct3 imm[4:1|11] opcode, rs1 = x1, rs2 = x2
    function automatic logic [31:0] encodeBranch(input logic [31:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic putWord(input int slot, input logic [31:0] addr, input logic [31:0] instr,
                           input logic [8*16-1:0] name);
        progTable[slot] = '{addr, instr, 1'b0, 32'd0, 3'd0};
        progName[slot]  = name;
    endtask

    task automatic putBranch(input int slot, input logic [31:0] addr, input logic [31:0] imm,
                             input logic [2:0] f3, input logic [8*16-1:0] name);
        progTable[slot] = '{addr, encodeBranch(imm, f3), 1'b1, imm, f3};
        progName[slot]  = name;
    endtask

    task automatic runCycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Reset edges land on rising clock edges
    task automatic applyReset();
        @(posedge clk);
        reset <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
    endtask

    initial begin
        reset = 1'b0;
        coverageErrors = 0;
        // Filler jumps to 0x00C or 0x010, both lead to the loop
        fillerImm = (($random(seed) & 1) != 0) ? 8 : 4;

        // Straight-line start, then jumps into the loop
        putWord  (0,  32'h0000_0000, 32'h0010_0093, "straightLine");
        putWord  (1,  32'h0000_0004, 32'h0020_0113, "straightLine");
        putBranch(2,  32'h0000_0008, fillerImm, 3'b001, "fillerBranch");
        putBranch(3,  32'h0000_000C, 32'h0000_07F4, 3'b000, "jumpToLoop");
        putBranch(4,  32'h0000_0010, 32'h0000_07F0, 3'b000, "jumpToLoop");
        // A and B share index 0x200 with tags 0 and 1
        putBranch(5,  32'h0000_0800, 32'h0000_0800, 3'b000, "branchA");
        putBranch(6,  32'h0000_1000, 32'h0000_0800, 3'b110, "toBranchB");
        putBranch(7,  32'h0000_1800, 32'h0000_0010, 3'b100, "branchB");
        putWord  (8,  32'h0000_1810, NOP, "loopBody");
        // Two hops back to A, B-immediates reach only 4 KiB
        putBranch(9,  32'h0000_1814, 32'hFFFF_F800, 3'b101, "loopBack");
        putBranch(10, 32'h0000_1014, 32'hFFFF_F7EC, 3'b111, "loopBack2");

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
        runCycles(RUN_FIRST);
        hitsFirst      = hitCount;
        redirectsFirst = redirectCount;

        // Second epoch must relearn every branch
        applyReset();
        runCycles(RUN_SECOND);

        if (hitsFirst == 0) begin
            $display("No BTB hit was seen while the loop ran");
            coverageErrors++;
        end
        if (redirectCount == redirectsFirst) begin
            $display("No redirect was seen after the second reset");
            coverageErrors++;
        end

        totalErrors = checkErrors + coverageErrors + u_dut.u_props.assertFails;
        $display("Errors: checker %0d, coverage %0d, assertions %0d",
                 checkErrors, coverageErrors, u_dut.u_props.assertFails);
        if (totalErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the stimulus finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule : tb_branchFrontEnd

`default_nettype wire

/* project.f */
hw/btbPkg.sv
hw/fetchPcGen.sv
hw/branchTargetBuffer.sv
hw/branchDecoder.sv
hw/branchFrontEnd.sv
verif/branchFrontEnd_properties.sv
verif/btbChecker.sv
verif/tb_branchFrontEnd.sv

/* Makefile */
# Verilator build and run for the branch front end

VERILATOR ?= verilator
TOP       ?= tb_branchFrontEnd
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= *** TEST PASSED ***

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
